/* cpu_pkg.sv */
////////////////////////////////////////////////////////////
// shared types and encodings for the execute slice
// modules refer to these by scoped names
////////////////////////////////////////////////////////////

package cpu_pkg;

	// data width is fixed by the instruction encoding
	localparam int BITS = 16;

	typedef logic [BITS - 1:0] word_t;	// data word and instruction
	typedef logic [3:0]        reg_idx_t;	// register file index
	typedef logic [4:0]        alu_op_t;	// alu operation, bit 4 selects single-reg ops

	// instruction class, top nibble of the instruction
	localparam logic [3:0] CLS_NOP        = 4'd0;
	localparam logic [3:0] CLS_IMM        = 4'd1;	// upper 12 bits of next immediate
	localparam logic [3:0] CLS_ALU_RR     = 4'd2;
	localparam logic [3:0] CLS_ALU_RI     = 4'd3;
	localparam logic [3:0] CLS_ALU_SINGLE = 4'd4;
	localparam logic [3:0] CLS_BRANCH     = 4'd5;

	// two-operand alu ops
	localparam alu_op_t ALU_MOV  = 5'd0;
	localparam alu_op_t ALU_ADD  = 5'd1;
	localparam alu_op_t ALU_ADC  = 5'd2;
	localparam alu_op_t ALU_SUB  = 5'd3;
	localparam alu_op_t ALU_SBB  = 5'd4;
	localparam alu_op_t ALU_AND  = 5'd5;
	localparam alu_op_t ALU_OR   = 5'd6;
	localparam alu_op_t ALU_XOR  = 5'd7;
	localparam alu_op_t ALU_CMP  = 5'd8;	// flags only
	localparam alu_op_t ALU_TEST = 5'd9;	// flags only

	// single-register alu ops
	localparam alu_op_t ALU_ASR  = 5'd16;
	localparam alu_op_t ALU_LSR  = 5'd17;
	localparam alu_op_t ALU_LSL  = 5'd18;
	localparam alu_op_t ALU_ROLC = 5'd19;	// through carry
	localparam alu_op_t ALU_RORC = 5'd20;	// through carry

	// branch conditions, ins[11:8]; the rest never branch
	localparam logic [3:0] COND_ALWAYS = 4'd0;
	localparam logic [3:0] COND_Z      = 4'd1;
	localparam logic [3:0] COND_NZ     = 4'd2;
	localparam logic [3:0] COND_S      = 4'd3;
	localparam logic [3:0] COND_NS     = 4'd4;
	localparam logic [3:0] COND_C      = 4'd5;
	localparam logic [3:0] COND_NC     = 4'd6;

endpackage

/* cpu_execute.sv */
////////////////////////////////////////////////////////////
// execute stage: decodes the instruction, holds the imm prefix,
// registers work for the alu and resolves branches
////////////////////////////////////////////////////////////
`timescale 1ns/10ps

module cpu_execute #(
	parameter int ADDRESS_BITS = 16
) (
	input  logic                      CLK,
	input  logic                      RSTb,
	input  cpu_pkg::word_t            instruction,
	input  logic                      is_executing,
	input  cpu_pkg::word_t            reg_a,
	input  cpu_pkg::word_t            reg_b,
	input  logic                      Z,
	input  logic                      C,
	input  logic                      S,
	output cpu_pkg::reg_idx_t         reg_a_idx,
	output cpu_pkg::reg_idx_t         reg_b_idx,
	output cpu_pkg::alu_op_t          alu_op,
	output cpu_pkg::word_t            alu_a,
	output cpu_pkg::word_t            alu_b,
	output cpu_pkg::reg_idx_t         alu_dest,
	output logic                      alu_valid,
	output logic                      load_pc,
	output logic [ADDRESS_BITS - 1:0] new_pc
);

	logic [3:0]                  ins_class;
	logic [cpu_pkg::BITS - 5:0]  imm_prefix;	// upper bits from a preceding imm
	logic                        imm_prefix_valid;
	cpu_pkg::word_t              imm;
	logic                        is_alu;
	cpu_pkg::alu_op_t            alu_op_next;
	logic                        cond_true;

	assign ins_class = instruction[15:12];
	assign reg_a_idx = instruction[7:4];	// also the destination
	assign reg_b_idx = instruction[3:0];

	assign imm = imm_prefix_valid ? {imm_prefix, instruction[3:0]}
				      : {{(cpu_pkg::BITS - 4){1'b0}}, instruction[3:0]};

	// alu op decode
	always_comb begin
		is_alu = 1'b1;
		alu_op_next = cpu_pkg::ALU_MOV;
		case (ins_class)
			cpu_pkg::CLS_ALU_RR,
			cpu_pkg::CLS_ALU_RI: alu_op_next = {1'b0, instruction[11:8]};
			cpu_pkg::CLS_ALU_SINGLE: alu_op_next = {1'b1, instruction[3:0]};
			cpu_pkg::CLS_NOP,
			cpu_pkg::CLS_IMM,
			cpu_pkg::CLS_BRANCH: is_alu = 1'b0;
			default: is_alu = 1'b0;	// unused classes run as nop
		endcase
	end

	// alu hand-off registers
	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			imm_prefix_valid <= 1'b0;
			alu_valid <= 1'b0;
			alu_op <= cpu_pkg::ALU_MOV;
			alu_a <= '0;
			alu_b <= '0;
			alu_dest <= '0;
		end else if (is_executing) begin
			imm_prefix_valid <= (ins_class == cpu_pkg::CLS_IMM);	// any other op uses it up
			alu_valid <= is_alu;
			alu_op <= alu_op_next;
			alu_a <= reg_a;
			alu_b <= (ins_class == cpu_pkg::CLS_ALU_RI) ? imm : reg_b;
			alu_dest <= instruction[7:4];
		end else begin
			alu_valid <= 1'b0;	// bubble, operands hold
		end
	end

	always_ff @(posedge CLK) begin
		if (is_executing && ins_class == cpu_pkg::CLS_IMM)
			imm_prefix <= instruction[cpu_pkg::BITS - 5:0];
	end

	// branch condition against the bypassed flags
	always_comb begin
		case (instruction[11:8])
			cpu_pkg::COND_ALWAYS: cond_true = 1'b1;
			cpu_pkg::COND_Z:      cond_true = Z;
			cpu_pkg::COND_NZ:     cond_true = !Z;
			cpu_pkg::COND_S:      cond_true = S;
			cpu_pkg::COND_NS:     cond_true = !S;
			cpu_pkg::COND_C:      cond_true = C;
			cpu_pkg::COND_NC:     cond_true = !C;
			default:              cond_true = 1'b0;	// never
		endcase
	end

	assign load_pc = is_executing && (ins_class == cpu_pkg::CLS_BRANCH) && cond_true;
	assign new_pc = imm[ADDRESS_BITS - 1:0];	// target is the immediate

endmodule

/* cpu_alu.sv */
////////////////////////////////////////////////////////////
// alu: result and write-back for the registered op, flag
// register with bypass so a following branch sees new flags
////////////////////////////////////////////////////////////
`timescale 1ns/10ps

module cpu_alu (
	input  logic              CLK,
	input  logic              RSTb,
	input  cpu_pkg::alu_op_t  alu_op,
	input  cpu_pkg::word_t    alu_a,
	input  cpu_pkg::word_t    alu_b,
	input  cpu_pkg::reg_idx_t alu_dest,
	input  logic              alu_valid,
	output logic              wr_en,
	output cpu_pkg::reg_idx_t wr_reg,
	output cpu_pkg::word_t    wr_data,
	output logic              Z,
	output logic              C,
	output logic              S
);

	localparam int BITS = cpu_pkg::BITS;

	cpu_pkg::word_t result;
	logic           carry;
	logic           keep_flags;	// mov and unused codes
	logic           z_new;
	logic           s_new;
	logic           z_r;
	logic           c_r;
	logic           s_r;

	always_comb begin
		result = alu_b;
		carry = c_r;
		keep_flags = 1'b0;
		case (alu_op)
			cpu_pkg::ALU_ADD:
				{carry, result} = {1'b0, alu_a} + {1'b0, alu_b};
			cpu_pkg::ALU_ADC:
				{carry, result} = {1'b0, alu_a} + {1'b0, alu_b} + (BITS + 1)'(c_r);
			cpu_pkg::ALU_SUB,
			cpu_pkg::ALU_CMP:
				{carry, result} = {1'b0, alu_a} - {1'b0, alu_b};	// top bit is borrow
			cpu_pkg::ALU_SBB:
				{carry, result} = {1'b0, alu_a} - {1'b0, alu_b} - (BITS + 1)'(c_r);
			cpu_pkg::ALU_AND,
			cpu_pkg::ALU_TEST: begin
				result = alu_a & alu_b;
				carry = 1'b0;
			end
			cpu_pkg::ALU_OR: begin
				result = alu_a | alu_b;
				carry = 1'b0;
			end
			cpu_pkg::ALU_XOR: begin
				result = alu_a ^ alu_b;
				carry = 1'b0;
			end
			cpu_pkg::ALU_ASR: begin
				result = {alu_a[BITS - 1], alu_a[BITS - 1:1]};
				carry = alu_a[0];
			end
			cpu_pkg::ALU_LSR: begin
				result = {1'b0, alu_a[BITS - 1:1]};
				carry = alu_a[0];
			end
			cpu_pkg::ALU_LSL: begin
				result = {alu_a[BITS - 2:0], 1'b0};
				carry = alu_a[BITS - 1];
			end
			cpu_pkg::ALU_ROLC: begin
				result = {alu_a[BITS - 2:0], c_r};
				carry = alu_a[BITS - 1];
			end
			cpu_pkg::ALU_RORC: begin
				result = {c_r, alu_a[BITS - 1:1]};
				carry = alu_a[0];
			end
			default: keep_flags = 1'b1;	// mov, result is B
		endcase
	end

	assign z_new = keep_flags ? z_r : (result == '0);
	assign s_new = keep_flags ? s_r : result[BITS - 1];

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			z_r <= 1'b0;
			c_r <= 1'b0;
			s_r <= 1'b0;
		end else if (alu_valid) begin
			z_r <= z_new;
			c_r <= carry;	// equals c_r for mov
			s_r <= s_new;
		end
	end

	// flags bypass the register while an op is in flight
	assign Z = alu_valid ? z_new : z_r;
	assign C = alu_valid ? carry : c_r;
	assign S = alu_valid ? s_new : s_r;

	assign wr_en = alu_valid && (alu_op != cpu_pkg::ALU_CMP) && (alu_op != cpu_pkg::ALU_TEST);
	assign wr_reg = alu_dest;
	assign wr_data = result;

endmodule

/* cpu_registers.sv */
////////////////////////////////////////////////////////////
// sixteen-word register file, two read ports with
// write-through so dependent ops see the value being written
////////////////////////////////////////////////////////////
`timescale 1ns/10ps

module cpu_registers (
	input  logic              CLK,
	input  logic              RSTb,
	input  cpu_pkg::reg_idx_t reg_a_idx,
	input  cpu_pkg::reg_idx_t reg_b_idx,
	input  logic              wr_en,
	input  cpu_pkg::reg_idx_t wr_reg,
	input  cpu_pkg::word_t    wr_data,
	output cpu_pkg::word_t    reg_a,
	output cpu_pkg::word_t    reg_b
);

	localparam int NUM_REGS = 16;

	cpu_pkg::word_t regs [NUM_REGS];

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			for (int i = 0; i < NUM_REGS; i++)
				regs[i] <= '0;
		end else if (wr_en) begin
			regs[wr_reg] <= wr_data;
		end
	end

	// write-through on both ports
	assign reg_a = (wr_en && wr_reg == reg_a_idx) ? wr_data : regs[reg_a_idx];
	assign reg_b = (wr_en && wr_reg == reg_b_idx) ? wr_data : regs[reg_b_idx];

endmodule

/* cpu_execute_core.sv */
////////////////////////////////////////////////////////////
// execute slice top: execute stage, alu and register file
// fed one instruction per cycle by an upstream fetch stage
////////////////////////////////////////////////////////////
`timescale 1ns/10ps

module cpu_execute_core #(
	parameter int ADDRESS_BITS = 16
) (
	input  logic                      CLK,
	input  logic                      RSTb,
	input  cpu_pkg::word_t            instruction,
	input  logic                      is_executing,
	output logic                      load_pc,
	output logic [ADDRESS_BITS - 1:0] new_pc,
	output logic                      wr_en,
	output cpu_pkg::reg_idx_t         wr_reg,
	output cpu_pkg::word_t            wr_data,
	output logic                      Z,
	output logic                      C,
	output logic                      S
);

	cpu_pkg::reg_idx_t reg_a_idx;
	cpu_pkg::reg_idx_t reg_b_idx;
	cpu_pkg::word_t    reg_a;
	cpu_pkg::word_t    reg_b;
	cpu_pkg::alu_op_t  alu_op;
	cpu_pkg::word_t    alu_a;
	cpu_pkg::word_t    alu_b;
	cpu_pkg::reg_idx_t alu_dest;
	logic              alu_valid;

	cpu_execute #(
		.ADDRESS_BITS(ADDRESS_BITS)
	) u_execute (
		.CLK(CLK), .RSTb(RSTb),
		.instruction(instruction), .is_executing(is_executing),
		.reg_a(reg_a), .reg_b(reg_b),
		.Z(Z), .C(C), .S(S),
		.reg_a_idx(reg_a_idx), .reg_b_idx(reg_b_idx),
		.alu_op(alu_op), .alu_a(alu_a), .alu_b(alu_b),
		.alu_dest(alu_dest), .alu_valid(alu_valid),
		.load_pc(load_pc), .new_pc(new_pc)
	);

	cpu_alu u_alu (
		.CLK(CLK), .RSTb(RSTb),
		.alu_op(alu_op), .alu_a(alu_a), .alu_b(alu_b),
		.alu_dest(alu_dest), .alu_valid(alu_valid),
		.wr_en(wr_en), .wr_reg(wr_reg), .wr_data(wr_data),
		.Z(Z), .C(C), .S(S)
	);

	cpu_registers u_registers (
		.CLK(CLK), .RSTb(RSTb),
		.reg_a_idx(reg_a_idx), .reg_b_idx(reg_b_idx),
		.wr_en(wr_en), .wr_reg(wr_reg), .wr_data(wr_data),
		.reg_a(reg_a), .reg_b(reg_b)
	);

endmodule

/* tb_cpu_execute_core.sv */
////////////////////////////////////////////////////////////
// self-checking testbench for the execute slice, directed and
// random instruction streams compared with a reference model
////////////////////////////////////////////////////////////
`timescale 1ns/10ps

module tb_cpu_execute_core;

	localparam int ADDRESS_BITS = 16;

	logic                      CLK;
	logic                      RSTb;
	cpu_pkg::word_t            instruction;
	logic                      is_executing;
	logic                      load_pc;
	logic [ADDRESS_BITS - 1:0] new_pc;
	logic                      wr_en;
	cpu_pkg::reg_idx_t         wr_reg;
	cpu_pkg::word_t            wr_data;
	logic                      Z, C, S;

	cpu_pkg::word_t            m_regs [16];	// model state
	logic                      m_z, m_c, m_s;
	logic [11:0]               m_prefix;
	logic                      m_prefix_valid;
	logic                      p_valid;	// op sitting in the alu stage
	cpu_pkg::alu_op_t          p_op;
	cpu_pkg::word_t            p_a, p_b;
	cpu_pkg::reg_idx_t         p_dest;
	logic [31:0]               lfsr;
	int                        errors;
	int                        checks;
	int                        timeouts;

	cpu_execute_core #(.ADDRESS_BITS(ADDRESS_BITS)) dut (
		.CLK(CLK), .RSTb(RSTb), .instruction(instruction), .is_executing(is_executing),
		.load_pc(load_pc), .new_pc(new_pc), .wr_en(wr_en), .wr_reg(wr_reg),
		.wr_data(wr_data), .Z(Z), .C(C), .S(S)
	);

	initial begin
		CLK = 1'b0;
		forever #50 CLK = ~CLK;
	end

	// fibonacci lfsr stepped once per bit taken
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
			v = {v[30:0], lfsr[0]};
		end
		return v;
	endfunction

	function automatic cpu_pkg::word_t random_ins();
		logic [2:0]  pick;
		logic [11:0] fields;
		pick = 3'(rand_bits(3));
		fields = 12'(rand_bits(12));
		case (pick)
			3'd0: return {cpu_pkg::CLS_NOP, fields};
			3'd1: return {cpu_pkg::CLS_IMM, fields};
			3'd3: return {cpu_pkg::CLS_ALU_RI, fields};
			3'd4: return {cpu_pkg::CLS_ALU_SINGLE, fields[11:4], 1'b0, fields[2:0]};
			3'd5: return {cpu_pkg::CLS_BRANCH, 1'b0, fields[10:0]};	// mostly real conditions
			default: return {cpu_pkg::CLS_ALU_RR, fields};
		endcase
	endfunction

	// expected alu result as {keep flags, carry, result}
	function automatic logic [17:0] alu_ref(input cpu_pkg::alu_op_t op, input cpu_pkg::word_t a,
			input cpu_pkg::word_t b, input logic cin);
		int          full;
		logic [15:0] r;
		logic        cy;
		logic        keep;
		r = b;
		cy = cin;
		keep = 1'b0;
		case (op)
			cpu_pkg::ALU_ADD, cpu_pkg::ALU_ADC: begin
				full = int'(a) + int'(b) + ((op == cpu_pkg::ALU_ADC) ? int'(cin) : 0);
				r = full[15:0];
				cy = full > 65535;
			end
			cpu_pkg::ALU_SUB, cpu_pkg::ALU_SBB, cpu_pkg::ALU_CMP: begin
				full = int'(a) - int'(b) - ((op == cpu_pkg::ALU_SBB) ? int'(cin) : 0);
				r = full[15:0];
				cy = full < 0;	// borrow
			end
			cpu_pkg::ALU_AND, cpu_pkg::ALU_TEST: {cy, r} = {1'b0, a & b};
			cpu_pkg::ALU_OR:   {cy, r} = {1'b0, a | b};
			cpu_pkg::ALU_XOR:  {cy, r} = {1'b0, a ^ b};
			cpu_pkg::ALU_ASR:  {r, cy} = {a[15], a};
			cpu_pkg::ALU_LSR:  {r, cy} = {1'b0, a};
			cpu_pkg::ALU_LSL:  {cy, r} = {a, 1'b0};
			cpu_pkg::ALU_ROLC: {cy, r} = {a, cin};
			cpu_pkg::ALU_RORC: {r, cy} = {cin, a};
			default: keep = 1'b1;	// mov and unused codes pass B
		endcase
		return {keep, cy, r};
	endfunction

	function automatic logic cond_holds(input logic [3:0] cond, input logic z, input logic c,
			input logic s);
		case (cond)
			cpu_pkg::COND_ALWAYS: return 1'b1;
			cpu_pkg::COND_Z:      return z;
			cpu_pkg::COND_NZ:     return !z;
			cpu_pkg::COND_S:      return s;
			cpu_pkg::COND_NS:     return !s;
			cpu_pkg::COND_C:      return c;
			cpu_pkg::COND_NC:     return !c;
			default:              return 1'b0;
		endcase
	endfunction

	task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("ERR %0t: %s is %0h, expected %0h", $time, what, got, exp);
		end
	endtask

	task automatic drive(input logic exec, input cpu_pkg::word_t ins);
		@(posedge CLK);
		#10;
		is_executing = exec;
		instruction = ins;
	endtask

	// compare mid-cycle and then step the model over the coming rising edge
	always @(negedge CLK) begin : compare_outputs
		logic [17:0]    ref_out;
		logic           exp_wr, exp_load;
		logic           fz, fc, fs;
		cpu_pkg::word_t imm;
		logic [3:0]     cls;
		if (RSTb !== 1'b1) begin
			for (int i = 0; i < 16; i++)
				m_regs[i] = '0;
			{m_z, m_c, m_s} = 3'b000;
			m_prefix = '0;
			m_prefix_valid = 1'b0;
			p_valid = 1'b0;
			p_op = '0;
			p_a = '0;
			p_b = '0;
			p_dest = '0;
		end else begin
			ref_out = alu_ref(p_op, p_a, p_b, m_c);
			exp_wr = p_valid && p_op != cpu_pkg::ALU_CMP && p_op != cpu_pkg::ALU_TEST;
			{fz, fc, fs} = {m_z, m_c, m_s};
			if (p_valid && !ref_out[17])
				{fz, fc, fs} = {ref_out[15:0] == 16'h0, ref_out[16], ref_out[15]};
			cls = instruction[15:12];
			imm = m_prefix_valid ? {m_prefix, instruction[3:0]} : {12'h0, instruction[3:0]};
			exp_load = is_executing && cls == cpu_pkg::CLS_BRANCH
				&& cond_holds(instruction[11:8], fz, fc, fs);
			check("wr_en", wr_en, exp_wr);
			if (exp_wr) begin
				check("wr_reg", wr_reg, p_dest);
				check("wr_data", wr_data, ref_out[15:0]);
			end
			check("flags ZCS", {Z, C, S}, {fz, fc, fs});
			check("load_pc", load_pc, exp_load);
			if (exp_load)
				check("new_pc", new_pc, imm[ADDRESS_BITS - 1:0]);
			if (exp_wr)
				m_regs[p_dest] = ref_out[15:0];
			{m_z, m_c, m_s} = {fz, fc, fs};
			p_valid = 1'b0;
			if (is_executing) begin
				p_valid = (cls == cpu_pkg::CLS_ALU_RR) || (cls == cpu_pkg::CLS_ALU_RI)
					|| (cls == cpu_pkg::CLS_ALU_SINGLE);
				p_op = (cls == cpu_pkg::CLS_ALU_SINGLE) ? {1'b1, instruction[3:0]}
									: {1'b0, instruction[11:8]};
				p_a = m_regs[instruction[7:4]];	// write-back above already applied
				p_b = (cls == cpu_pkg::CLS_ALU_RI) ? imm : m_regs[instruction[3:0]];
				p_dest = instruction[7:4];
				m_prefix_valid = (cls == cpu_pkg::CLS_IMM);
				if (cls == cpu_pkg::CLS_IMM)
					m_prefix = instruction[11:0];
			end
		end
	end

	initial begin : stimulus
		cpu_pkg::word_t val;
		int             waited;
		RSTb = 1'b0;
		instruction = '0;
		is_executing = 1'b0;
		lfsr = 32'h4cce;
		errors = 0;
		checks = 0;
		timeouts = 0;
		repeat (2) @(posedge CLK);
		#10 RSTb = 1'b1;
		waited = 0;
		while ({wr_en, load_pc, Z, C, S} !== 5'b00000 && waited < 10) begin
			@(negedge CLK);
			waited++;
		end
		if ({wr_en, load_pc, Z, C, S} !== 5'b00000) begin
			$display("timeout: the DUT outputs never settled low after reset");
			timeouts++;
		end
		for (int r = 0; r < 16; r++) begin	// 16-bit immediate into every register
			val = 16'((r + 1) * 40503) ^ 16'h5a5a;
			drive(1'b1, {cpu_pkg::CLS_IMM, val[15:4]});
			drive(1'b1, {cpu_pkg::CLS_ALU_RI, 4'd0, 4'(r), val[3:0]});
		end
		for (int r = 0; r < 16; r++)
			drive(1'b1, {cpu_pkg::CLS_ALU_RR, 4'd0, 4'(r), 4'(r + 1)});
		for (int op = 1; op < 16; op++)	// repeats of adc and sbb chain the carry
			repeat (4) drive(1'b1, {cpu_pkg::CLS_ALU_RR, 4'(op), 8'(rand_bits(8))});
		for (int op = 0; op < 8; op++)
			repeat (4) drive(1'b1, {cpu_pkg::CLS_ALU_SINGLE, 4'h0, 4'(rand_bits(4)), 4'(op)});
		// long immediate once and then the short one
		drive(1'b1, {cpu_pkg::CLS_IMM, 12'hbee});
		drive(1'b1, {cpu_pkg::CLS_ALU_RI, 4'(cpu_pkg::ALU_ADD), 4'd3, 4'h5});
		drive(1'b1, {cpu_pkg::CLS_ALU_RI, 4'(cpu_pkg::ALU_ADD), 4'd3, 4'h5});
		for (int cond = 0; cond < 9; cond++) begin
			drive(1'b1, {cpu_pkg::CLS_ALU_RR, 4'(cpu_pkg::ALU_SUB), 4'd7, 4'd7});
			drive(1'b1, {cpu_pkg::CLS_BRANCH, 4'(cond), 8'(rand_bits(8))});
			drive(1'b1, {cpu_pkg::CLS_ALU_RR, 4'(cpu_pkg::ALU_ADD), 8'(rand_bits(8))});
			drive(1'b1, {cpu_pkg::CLS_IMM, 12'(rand_bits(12))});
			drive(1'b1, {cpu_pkg::CLS_BRANCH, 4'(cond), 8'(rand_bits(8))});
		end
		repeat (600) begin
			if (rand_bits(3) == 0)
				drive(1'b0, {cpu_pkg::CLS_BRANCH, 12'h0});	// a bubble must not branch
			else
				drive(1'b1, random_ins());
		end
		drive(1'b0, '0);
		waited = 0;
		while (wr_en !== 1'b0 && waited < 10) begin
			@(negedge CLK);
			waited++;
		end
		if (wr_en !== 1'b0) begin
			$display("timeout: write-back never went idle after the last instruction");
			timeouts++;
		end
		repeat (2) @(posedge CLK);
		$display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
		if (errors == 0 && timeouts == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

/* all.f */
cpu_pkg.sv
cpu_execute.sv
cpu_alu.sv
cpu_registers.sv
cpu_execute_core.sv
tb_cpu_execute_core.sv

/* Bender.yml */
package:
  name: cpu_execute_core

sources:
  - cpu_pkg.sv
  - cpu_execute.sv
  - cpu_alu.sv
  - cpu_registers.sv
  - cpu_execute_core.sv
  - target: test
    files:
      - tb_cpu_execute_core.sv
